// ==== src.f ====
hdl/l2_geom_pkg.sv
hdl/l2_port_pkg.sv
hdl/l2_req_buf.sv
hdl/l2_tag_store.sv
hdl/l2_data_store.sv
hdl/l2_plru.sv
hdl/l2_fsm_main.sv
hdl/l2_cache_top.sv
dv/l2_mem_model.sv
dv/l2_cache_tb.sv

// ==== dv/l2_cache_tb.sv ====
`timescale 1ns/10ps

module l2_cache_tb;
    import l2_geom_pkg::*;

    localparam int reset_cycles = 16;
    localparam int entry_cycles = 40;   // budget per table entry

    localparam logic [1:0] from_ic   = 2'd0;
    localparam logic [1:0] from_dc   = 2'd1;
    localparam logic [1:0] from_both = 2'd2;   // data column holds the icache address

    typedef struct packed {
        logic [1:0]  src;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] data;
        logic        exp_hit;   // data_ok one cycle after addr_ok
        logic        exp_wb;    // writebacks seen during the entry
    } entry_t;

    logic               clk;
    logic               rstn;
    logic               icache_req, icache_addr_ok, icache_data_ok;
    logic [word_w-1:0]  icache_addr, icache_rdata;
    logic               dcache_req, dcache_wr, dcache_addr_ok, dcache_data_ok;
    logic [word_w-1:0]  dcache_addr, dcache_wdata, dcache_rdata;
    logic               mem_req_r, mem_req_w, mem_rdy;
    logic               mem_addr_ok_r, mem_addr_ok_w, mem_data_ok;
    logic [word_w-1:0]  mem_addr;
    logic [block_w-1:0] mem_wdata, mem_rdata;

    entry_t            stim [$];
    logic [word_w-1:0] shadow [1024];
    int                errors;
    int                wb_count;
    int                cycle;
    int                limit;

    l2_cache_top dut0 (.*);
    l2_mem_model mem0 (.*);

    always #20 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_entry(input logic [1:0] src, input logic wr, input logic [31:0] addr,
                             input logic [31:0] data, input logic exp_hit, input logic exp_wb);
        entry_t e;
        e.src     = src;
        e.wr      = wr;
        e.addr    = addr;
        e.data    = data;
        e.exp_hit = exp_hit;
        e.exp_wb  = exp_wb;
        stim.push_back(e);
    endtask

    function automatic logic strobe_level(input int sel);
        case (sel)
            0:       return icache_addr_ok;
            1:       return icache_data_ok;
            2:       return dcache_addr_ok;
            default: return dcache_data_ok;
        endcase
    endfunction

    // n counts falling edges up to the strobe
    task automatic wait_strobe(input int sel, input logic ic_quiet, output int n);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (ic_quiet)
                compare_value("icache_addr_ok", icache_addr_ok, 1'b0);
        end while (!strobe_level(sel));
    endtask

    task automatic finish_access(input logic dc, input logic wr, input logic [31:0] addr,
                                 input logic [31:0] data, input logic exp_hit,
                                 input logic ic_quiet);
        int n;
        wait_strobe(dc ? 2 : 0, ic_quiet, n);
        @(posedge clk);
        if (dc) begin
            dcache_req <= 1'b0;
            dcache_wr  <= 1'b0;
        end else begin
            icache_req <= 1'b0;
        end
        if (wr) begin
            shadow[addr[11:2]] = data;
        end else begin
            wait_strobe(dc ? 3 : 1, ic_quiet, n);
            if (exp_hit)
                compare_value("data_ok delay", n, 1);
            compare_value(dc ? "dcache_rdata" : "icache_rdata",
                          dc ? dcache_rdata : icache_rdata, shadow[addr[11:2]]);
        end
    endtask

    task automatic apply_entry(input int k);
        entry_t e;
        int     err0;
        int     wb0;
        e    = stim[k];
        err0 = errors;
        wb0  = wb_count;
        @(posedge clk);
        if (e.src != from_ic) begin
            dcache_req   <= 1'b1;
            dcache_wr    <= e.wr;
            dcache_addr  <= e.addr;
            dcache_wdata <= e.data;
        end
        if (e.src != from_dc) begin
            icache_req  <= 1'b1;
            icache_addr <= (e.src == from_both) ? e.data : e.addr;
        end
        if (e.src == from_ic) begin
            finish_access(1'b0, 1'b0, e.addr, e.data, e.exp_hit, 1'b0);
        end else begin
            finish_access(1'b1, e.wr, e.addr, e.data, e.exp_hit, e.src == from_both);
            if (e.src == from_both)
                finish_access(1'b0, 1'b0, e.data, e.data, 1'b0, 1'b0);   // icache after
        end
        compare_value("writeback count", wb_count - wb0, e.exp_wb);
        $display("entry %0d addr %h: %s", k, e.addr, (errors == err0) ? "ok" : "mismatch");
    endtask

    ////////////////////////////////////////////////////////////////////
    // monitors
    ////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rstn && mem_req_w && mem_addr_ok_w) begin
            wb_count++;
            for (int w = 0; w < words_per_block; w++)
                compare_value("mem_wdata", mem_wdata[w*word_w +: word_w],
                              shadow[mem_addr[11:2] + w]);
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= limit) begin
            $display("timeout: the cache stopped answering after %0d cycles", cycle);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////
    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        icache_req   = 1'b0;
        icache_addr  = '0;
        dcache_req   = 1'b0;
        dcache_wr    = 1'b0;
        dcache_addr  = '0;
        dcache_wdata = '0;
        errors       = 0;
        wb_count     = 0;
        cycle        = 0;
        for (int i = 0; i < 1024; i++)
            shadow[i] = (i * 4) ^ 32'h5a5a0000;
        // misses and then hits from each side
        add_entry(from_ic, 1'b0, 32'h0000_0104, 32'h0, 1'b0, 1'b0);
        add_entry(from_ic, 1'b0, 32'h0000_0104, 32'h0, 1'b1, 1'b0);
        add_entry(from_dc, 1'b0, 32'h0000_0228, 32'h0, 1'b0, 1'b0);
        add_entry(from_dc, 1'b0, 32'h0000_0228, 32'h0, 1'b1, 1'b0);
        // write hit and block read back
        add_entry(from_dc, 1'b1, 32'h0000_0224, 32'hdead_0001, 1'b0, 1'b0);
        add_entry(from_dc, 1'b0, 32'h0000_0224, 32'h0, 1'b1, 1'b0);
        add_entry(from_dc, 1'b0, 32'h0000_0220, 32'h0, 1'b1, 1'b0);
        add_entry(from_dc, 1'b0, 32'h0000_022c, 32'h0, 1'b1, 1'b0);
        // set 5 filled dirty without eviction
        add_entry(from_dc, 1'b1, 32'h0000_0054, 32'hbeef_0000, 1'b0, 1'b0);
        add_entry(from_dc, 1'b1, 32'h0000_0154, 32'hbeef_0001, 1'b0, 1'b0);
        add_entry(from_dc, 1'b1, 32'h0000_0258, 32'hbeef_0002, 1'b0, 1'b0);
        add_entry(from_dc, 1'b1, 32'h0000_035c, 32'hbeef_0003, 1'b0, 1'b0);
        // fifth block evicts and each read back pushes out the next pseudo-LRU way
        add_entry(from_dc, 1'b0, 32'h0000_0450, 32'h0, 1'b0, 1'b1);
        add_entry(from_dc, 1'b0, 32'h0000_0054, 32'h0, 1'b0, 1'b1);
        add_entry(from_dc, 1'b0, 32'h0000_0154, 32'h0, 1'b0, 1'b1);
        add_entry(from_dc, 1'b0, 32'h0000_0258, 32'h0, 1'b0, 1'b1);
        add_entry(from_dc, 1'b0, 32'h0000_035c, 32'h0, 1'b0, 1'b0);
        // both sides at once
        add_entry(from_both, 1'b0, 32'h0000_00a0, 32'h0000_01b4, 1'b0, 1'b0);
        add_entry(from_both, 1'b0, 32'h0000_00a8, 32'h0000_01b0, 1'b0, 1'b0);
        limit = stim.size() * entry_cycles;

        repeat (reset_cycles) @(posedge clk);
        rstn <= 1'b1;
        repeat (8) begin
            @(negedge clk);
            compare_value("addr_ok/data_ok/mem_req_r/mem_req_w/mem_rdy",
                          {icache_addr_ok, dcache_addr_ok, icache_data_ok, dcache_data_ok,
                           mem_req_r, mem_req_w, mem_rdy}, '0);
        end
        $display("idle strobes: %s", (errors == 0) ? "ok" : "mismatch");

        for (int k = 0; k < stim.size(); k++)
            apply_entry(k);
        repeat (4) @(posedge clk);
        $display("summary: %0d entries, %0d writebacks, %0d errors",
                 stim.size(), wb_count, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== dv/l2_mem_model.sv ====
`timescale 1ns/10ps

module l2_mem_model (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            mem_req_r,
    input  logic                            mem_req_w,
    input  logic [l2_geom_pkg::word_w-1:0]  mem_addr,
    input  logic [l2_geom_pkg::block_w-1:0] mem_wdata,
    input  logic                            mem_rdy,
    output logic                            mem_addr_ok_r,
    output logic                            mem_addr_ok_w,
    output logic                            mem_data_ok,
    output logic [l2_geom_pkg::block_w-1:0] mem_rdata
);
    import l2_geom_pkg::*;

    logic [word_w-1:0] mem [1024];   // word array, open to hierarchical reads
    logic [2:0]        cnt;          // cycles left before the next answer
    logic              rd_pend;      // read accepted, block not yet returned
    logic [9:0]        rd_word;
    integer            seed;

    initial begin
        seed = 32'hff04;
        for (int i = 0; i < 1024; i++)
            mem[i] = (i * 4) ^ 32'h5a5a0000;   // byte address of the word
    end

    always @(posedge clk) begin
        if (!rstn) begin
            mem_addr_ok_r <= 1'b0;
            mem_addr_ok_w <= 1'b0;
            mem_data_ok   <= 1'b0;
            mem_rdata     <= '0;
            cnt           <= '0;
            rd_pend       <= 1'b0;
        end else begin
            mem_addr_ok_r <= 1'b0;
            mem_addr_ok_w <= 1'b0;
            mem_data_ok   <= 1'b0;
            if (rd_pend) begin
                if (cnt > 1) begin
                    cnt <= cnt - 1'b1;
                end else if (mem_rdy) begin
                    mem_data_ok <= 1'b1;
                    rd_pend     <= 1'b0;
                    cnt         <= '0;
                    for (int w = 0; w < words_per_block; w++)
                        mem_rdata[w*word_w +: word_w] <= mem[rd_word + w];
                end
            end else if (cnt > 1) begin
                cnt <= cnt - 1'b1;
            end else if (cnt == 1) begin
                cnt <= '0;
                if (mem_req_w) begin
                    mem_addr_ok_w <= 1'b1;   // block lands with the accept
                    for (int w = 0; w < words_per_block; w++)
                        mem[mem_addr[11:2] + w] <= mem_wdata[w*word_w +: word_w];
                end else begin
                    mem_addr_ok_r <= 1'b1;
                    rd_pend       <= 1'b1;
                    rd_word       <= mem_addr[11:2];
                    cnt           <= 3'd1 + 3'({$random(seed)} % 4);
                end
            end else if ((mem_req_r || mem_req_w) && !mem_addr_ok_r && !mem_addr_ok_w) begin
                cnt <= 3'd1 + 3'({$random(seed)} % 4);   // 1 to 4 cycles
            end
        end
    end

endmodule

// ==== hdl/l2_cache_top.sv ====
`timescale 1ns/10ps

module l2_cache_top (
    input  logic                            clk,
    input  logic                            rstn,
    // icache side
    input  logic                            icache_req,
    input  logic [l2_geom_pkg::word_w-1:0]  icache_addr,
    output logic                            icache_addr_ok,
    output logic                            icache_data_ok,
    output logic [l2_geom_pkg::word_w-1:0]  icache_rdata,
    // dcache side
    input  logic                            dcache_req,
    input  logic                            dcache_wr,
    input  logic [l2_geom_pkg::word_w-1:0]  dcache_addr,
    input  logic [l2_geom_pkg::word_w-1:0]  dcache_wdata,
    output logic                            dcache_addr_ok,
    output logic                            dcache_data_ok,
    output logic [l2_geom_pkg::word_w-1:0]  dcache_rdata,
    // memory side
    output logic                            mem_req_r,
    output logic                            mem_req_w,
    output logic [l2_geom_pkg::word_w-1:0]  mem_addr,
    output logic [l2_geom_pkg::block_w-1:0] mem_wdata,
    output logic                            mem_rdy,
    input  logic                            mem_addr_ok_r,
    input  logic                            mem_addr_ok_w,
    input  logic                            mem_data_ok,
    input  logic [l2_geom_pkg::block_w-1:0] mem_rdata
);
    import l2_geom_pkg::*;

    logic                  buf_we;
    logic [1:0]            src;
    logic [tag_w-1:0]      tag;
    logic [index_w-1:0]    index;
    logic [word_sel_w-1:0] word;
    logic [word_w-1:0]     wdata;
    logic [num_ways-1:0]   hit;
    logic                  dirty;
    logic [tag_w-1:0]      victim_tag;
    logic [way_w-1:0]      victim;
    logic [num_ways-1:0]   use_way;
    logic [num_ways-1:0]   way_we;
    logic                  refill;
    logic                  tag_we;
    logic [way_w-1:0]      dirty_way;
    logic                  dirty_set;
    logic                  dirty_clr;
    logic [way_w-1:0]      rd_way;
    logic                  ret_sel;
    logic                  mem_addr_sel;
    logic [word_w-1:0]     rdata;

    // block aligned, writeback uses the victim's tag
    assign mem_addr = {mem_addr_sel ? victim_tag : tag, index, {(word_sel_w + 2){1'b0}}};

    assign icache_rdata = rdata;
    assign dcache_rdata = rdata;

    l2_req_buf u_req_buf (
        .clk, .rstn, .buf_we,
        .icache_req, .icache_addr,
        .dcache_req, .dcache_wr, .dcache_addr, .dcache_wdata,
        .src, .tag, .index, .word, .wdata
    );

    l2_tag_store u_tag_store (
        .clk, .rstn, .index, .tag, .tag_we,
        .dirty_way, .dirty_set, .dirty_clr,
        .hit, .dirty, .victim_tag
    );

    l2_data_store u_data_store (
        .clk, .index, .word, .wdata, .way_we, .refill,
        .refill_way (dirty_way),
        .mem_rdata, .rd_way, .ret_sel,
        .rdata,
        .wb_block   (mem_wdata)
    );

    l2_plru u_plru (
        .clk, .rstn, .index, .use_way, .victim
    );

    l2_fsm_main u_fsm_main (
        .clk, .rstn, .icache_req, .dcache_req,
        .src, .hit, .dirty, .victim,
        .mem_addr_ok_r, .mem_addr_ok_w, .mem_data_ok,
        .buf_we, .icache_addr_ok, .dcache_addr_ok, .icache_data_ok, .dcache_data_ok,
        .mem_req_r, .mem_req_w, .mem_rdy,
        .use_way, .way_we, .refill, .tag_we,
        .dirty_way, .dirty_set, .dirty_clr,
        .rd_way, .ret_sel, .mem_addr_sel
    );

endmodule

// ==== hdl/l2_fsm_main.sv ====
`timescale 1ns/10ps

module l2_fsm_main (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             icache_req,
    input  logic                             dcache_req,
    input  logic [1:0]                       src,
    input  logic [l2_geom_pkg::num_ways-1:0] hit,
    input  logic                             dirty,
    input  logic [l2_geom_pkg::way_w-1:0]    victim,
    input  logic                             mem_addr_ok_r,
    input  logic                             mem_addr_ok_w,
    input  logic                             mem_data_ok,
    output logic                             buf_we,
    output logic                             icache_addr_ok,
    output logic                             dcache_addr_ok,
    output logic                             icache_data_ok,
    output logic                             dcache_data_ok,
    output logic                             mem_req_r,
    output logic                             mem_req_w,
    output logic                             mem_rdy,
    output logic [l2_geom_pkg::num_ways-1:0] use_way,
    output logic [l2_geom_pkg::num_ways-1:0] way_we,
    output logic                             refill,
    output logic                             tag_we,
    output logic [l2_geom_pkg::way_w-1:0]    dirty_way,
    output logic                             dirty_set,
    output logic                             dirty_clr,
    output logic [l2_geom_pkg::way_w-1:0]    rd_way,
    output logic                             ret_sel,
    output logic                             mem_addr_sel
);
    import l2_geom_pkg::*;
    import l2_port_pkg::*;

    logic [3:0]       state;
    logic [3:0]       next_state;
    logic [way_w-1:0] vway;      // victim held through writeback and refill
    logic [way_w-1:0] hit_way;
    logic             is_read;

    assign is_read = (src == src_icache) || (src == src_dcache_rd);

    always_comb begin
        hit_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (hit[w])
                hit_way = w[way_w-1:0];   // lowest way wins
        end
    end

    ////////////////////////////////////////////////////////////////////
    // state and victim registers
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (state == st_lookup && !(|hit))
            vway <= victim;
    end

    always_comb begin
        case (state)
            st_idle:         next_state = (dcache_req || icache_req) ? st_lookup : st_idle;
            st_lookup:       next_state = (|hit) ? st_idle : st_check_dirty;
            st_check_dirty:  next_state = st_check_dirty1;
            st_check_dirty1: next_state = dirty ? st_writeback : st_refill_req;
            st_writeback:    next_state = mem_addr_ok_w ? st_refill_req : st_writeback;
            st_refill_req:   next_state = mem_addr_ok_r ? st_refill_wait : st_refill_req;
            st_refill_wait: begin
                if (!mem_data_ok)
                    next_state = st_refill_wait;
                else
                    next_state = is_read ? st_idle : st_refill_write;
            end
            default:         next_state = st_idle;   // refill_write included
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // per-state strobes
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        buf_we         = 1'b0;
        icache_addr_ok = 1'b0;
        dcache_addr_ok = 1'b0;
        icache_data_ok = 1'b0;
        dcache_data_ok = 1'b0;
        mem_req_r      = 1'b0;
        mem_req_w      = 1'b0;
        mem_rdy        = 1'b0;
        use_way        = '0;
        way_we         = '0;
        refill         = 1'b0;
        tag_we         = 1'b0;
        dirty_way      = vway;
        dirty_set      = 1'b0;
        dirty_clr      = 1'b0;
        rd_way         = vway;
        ret_sel        = 1'b0;
        mem_addr_sel   = 1'b0;
        case (state)
            st_idle: begin
                buf_we = 1'b1;
                if (dcache_req)
                    dcache_addr_ok = 1'b1;
                else if (icache_req)
                    icache_addr_ok = 1'b1;
            end
            st_lookup: begin
                rd_way    = hit_way;
                dirty_way = hit_way;
                if (|hit) begin
                    use_way[hit_way] = 1'b1;
                    if (src == src_dcache_wr) begin
                        way_we[hit_way] = 1'b1;
                        dirty_set       = 1'b1;
                    end
                    icache_data_ok = (src == src_icache);
                    dcache_data_ok = (src == src_dcache_rd);
                end
            end
            st_writeback: begin
                mem_req_w    = 1'b1;
                mem_addr_sel = 1'b1;            // victim tag on the bus
                dirty_clr    = mem_addr_ok_w;   // block has left with the request
            end
            st_refill_req: begin
                mem_req_r = 1'b1;
            end
            st_refill_wait: begin
                mem_rdy = 1'b1;
                if (mem_data_ok) begin
                    refill  = 1'b1;
                    tag_we  = 1'b1;
                    ret_sel = 1'b1;
                    if (is_read)
                        use_way[vway] = 1'b1;
                    icache_data_ok = (src == src_icache);
                    dcache_data_ok = (src == src_dcache_rd);
                end
            end
            st_refill_write: begin
                way_we[vway]  = 1'b1;   // merge the store into the new block
                use_way[vway] = 1'b1;
                dirty_set     = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/l2_plru.sv ====
`timescale 1ns/10ps

module l2_plru (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [l2_geom_pkg::index_w-1:0]  index,
    input  logic [l2_geom_pkg::num_ways-1:0] use_way,
    output logic [l2_geom_pkg::way_w-1:0]    victim
);
    import l2_geom_pkg::*;

    // bit 0 root, bit 1 picks in ways 0/1, bit 2 picks in ways 2/3
    logic [num_sets-1:0][2:0] tree;
    logic [way_w-1:0]         used;

    always_comb begin
        used = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (use_way[w])
                used = w[way_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tree <= '0;
        end else if (|use_way) begin
            tree[index][0] <= ~used[1];   // point at the other half
            if (used[1])
                tree[index][2] <= ~used[0];
            else
                tree[index][1] <= ~used[0];
        end
    end

    assign victim = tree[index][0] ? {1'b1, tree[index][2]} : {1'b0, tree[index][1]};

endmodule

// ==== hdl/l2_data_store.sv ====
`timescale 1ns/10ps

module l2_data_store (
    input  logic                                clk,
    input  logic [l2_geom_pkg::index_w-1:0]     index,
    input  logic [l2_geom_pkg::word_sel_w-1:0]  word,
    input  logic [l2_geom_pkg::word_w-1:0]      wdata,
    input  logic [l2_geom_pkg::num_ways-1:0]    way_we,
    input  logic                                refill,
    input  logic [l2_geom_pkg::way_w-1:0]       refill_way,
    input  logic [l2_geom_pkg::block_w-1:0]     mem_rdata,
    input  logic [l2_geom_pkg::way_w-1:0]       rd_way,
    input  logic                                ret_sel,
    output logic [l2_geom_pkg::word_w-1:0]      rdata,
    output logic [l2_geom_pkg::block_w-1:0]     wb_block
);
    import l2_geom_pkg::*;

    logic [block_w-1:0] blk [num_ways][num_sets];

    // word merge per way, whole block on refill
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (way_we[w])
                blk[w][index][word*word_w +: word_w] <= wdata;
        end
        if (refill)
            blk[refill_way][index] <= mem_rdata;
    end

    assign wb_block = blk[rd_way][index];

    // returned word goes straight out during refill
    assign rdata = ret_sel ? mem_rdata[word*word_w +: word_w]
                           : wb_block[word*word_w +: word_w];

endmodule

// ==== hdl/l2_tag_store.sv ====
`timescale 1ns/10ps

module l2_tag_store (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [l2_geom_pkg::index_w-1:0]  index,
    input  logic [l2_geom_pkg::tag_w-1:0]    tag,
    input  logic                             tag_we,
    input  logic [l2_geom_pkg::way_w-1:0]    dirty_way,
    input  logic                             dirty_set,
    input  logic                             dirty_clr,
    output logic [l2_geom_pkg::num_ways-1:0] hit,
    output logic                             dirty,
    output logic [l2_geom_pkg::tag_w-1:0]    victim_tag
);
    import l2_geom_pkg::*;

    logic [tag_w-1:0]                   tag_arr [num_ways][num_sets];
    logic [num_ways-1:0][num_sets-1:0]  valid;
    logic [num_ways-1:0][num_sets-1:0]  dirty_tbl;

    ////////////////////////////////////////////////////////////////////
    // lookup, all combinational from the buffered index
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit[w] = valid[w][index] && (tag_arr[w][index] == tag);
        end
    end

    assign dirty      = dirty_tbl[dirty_way][index];
    assign victim_tag = tag_arr[dirty_way][index];   // address of the block going out

    ////////////////////////////////////////////////////////////////////
    // updates
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid     <= '0;
            dirty_tbl <= '0;
        end else begin
            if (tag_we)
                valid[dirty_way][index] <= 1'b1;
            if (dirty_set)
                dirty_tbl[dirty_way][index] <= 1'b1;
            else if (dirty_clr)
                dirty_tbl[dirty_way][index] <= 1'b0;   // clean after writeback
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we)
            tag_arr[dirty_way][index] <= tag;
    end

endmodule

// ==== hdl/l2_req_buf.sv ====
`timescale 1ns/10ps

module l2_req_buf (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               buf_we,
    input  logic                               icache_req,
    input  logic [l2_geom_pkg::word_w-1:0]     icache_addr,
    input  logic                               dcache_req,
    input  logic                               dcache_wr,
    input  logic [l2_geom_pkg::word_w-1:0]     dcache_addr,
    input  logic [l2_geom_pkg::word_w-1:0]     dcache_wdata,
    output logic [1:0]                         src,
    output logic [l2_geom_pkg::tag_w-1:0]      tag,
    output logic [l2_geom_pkg::index_w-1:0]    index,
    output logic [l2_geom_pkg::word_sel_w-1:0] word,
    output logic [l2_geom_pkg::word_w-1:0]     wdata
);
    import l2_geom_pkg::*;
    import l2_port_pkg::*;

    logic [word_w-1:0] sel_addr;

    assign sel_addr = dcache_req ? dcache_addr : icache_addr;   // dcache wins

    always_ff @(posedge clk) begin
        if (!rstn) begin
            src <= src_none;
        end else if (buf_we) begin
            if (dcache_req)
                src <= dcache_wr ? src_dcache_wr : src_dcache_rd;
            else if (icache_req)
                src <= src_icache;
            else
                src <= src_none;   // nothing asked this cycle
        end
    end

    // address fields and store data
    always_ff @(posedge clk) begin
        if (buf_we) begin
            tag   <= sel_addr[word_w-1 -: tag_w];
            index <= sel_addr[word_sel_w+2 +: index_w];
            word  <= sel_addr[2 +: word_sel_w];
            wdata <= dcache_wdata;
        end
    end

endmodule

// ==== hdl/l2_port_pkg.sv ====
package l2_port_pkg;

    // where the buffered request came from
    localparam logic [1:0] src_none      = 2'd0;
    localparam logic [1:0] src_icache    = 2'd1;
    localparam logic [1:0] src_dcache_rd = 2'd2;
    localparam logic [1:0] src_dcache_wr = 2'd3;

    ////////////////////////////////////////////////////////////////////
    // main FSM states
    ////////////////////////////////////////////////////////////////////
    localparam logic [3:0] st_idle         = 4'd0;
    localparam logic [3:0] st_lookup       = 4'd1;
    localparam logic [3:0] st_check_dirty  = 4'd2;
    localparam logic [3:0] st_check_dirty1 = 4'd3;
    localparam logic [3:0] st_writeback    = 4'd4;
    localparam logic [3:0] st_refill_req   = 4'd5;
    localparam logic [3:0] st_refill_wait  = 4'd6;
    localparam logic [3:0] st_refill_write = 4'd7;

endpackage

// ==== hdl/l2_geom_pkg.sv ====
package l2_geom_pkg;

    ////////////////////////////////////////////////////////////////////
    // ways and sets
    ////////////////////////////////////////////////////////////////////
    localparam int num_ways = 4;
    localparam int way_w    = 2;   // way number
    localparam int num_sets = 16;
    localparam int index_w  = 4;   // set index, address bits 7:4

    ////////////////////////////////////////////////////////////////////
    // words and blocks
    ////////////////////////////////////////////////////////////////////
    localparam int words_per_block = 4;
    localparam int word_sel_w      = 2;   // address bits 3:2
    localparam int word_w          = 32;
    localparam int block_w         = words_per_block * word_w;

    // what is left of the address above index and block offset
    localparam int tag_w = word_w - index_w - word_sel_w - 2;

endpackage
